// ==== Bender.yml ====
package:
  name: led_matrix

export_include_dirs:
  - design

sources:
  - files:
      - design/matrix_pkg.sv
      - design/uart_rx.sv
      - design/command_parser.sv
      - design/framebuffer_ram.sv
      - design/framebuffer_fetch.sv
      - design/matrix_scan.sv
      - design/led_matrix_top.sv
  - target: test
    files:
      - tb/led_matrix_tb.sv

// ==== compile.f ====
+incdir+design
design/matrix_pkg.sv
design/uart_rx.sv
design/command_parser.sv
design/framebuffer_ram.sv
design/framebuffer_fetch.sv
design/matrix_scan.sv
design/led_matrix_top.sv
tb/led_matrix_tb.sv

// ==== design/command_parser.sv ====
// serial command decoder, framebuffer byte writes, enable masks, command counter
`timescale 1ns/1ps
`default_nettype none
`include "matrix_defs.svh"

module command_parser (
	input  wire logic                  clk_root,
	input  wire logic                  reset,
	input  wire logic [7:0]            rx_data,
	input  wire logic                  rx_valid,
	output logic [`FB_ADDR_BITS:0]     wr_addr,
	output logic [7:0]                 wr_data,
	output logic                       wr_en,
	output logic [2:0]                 rgb_enable,
	output logic [4:0]                 brightness_enable,
	output logic [7:0]                 commands_done
);

	localparam logic [7:0] CMD_LINE = 8'h4C;
	localparam logic [7:0] CMD_BRIGHT = 8'h42;
	localparam logic [7:0] CMD_COLOUR = 8'h43;
	localparam int LINE_BITS = $clog2(2 * `MATRIX_ROW_PAIRS);
	localparam int IDX_BITS = $clog2(2 * `MATRIX_COLS);

	matrix_pkg::parser_state_t state;
	// which mask the next byte goes to, 1 for colour
	logic mask_is_colour;
	logic [LINE_BITS-1:0] line_num;
	logic [IDX_BITS-1:0] byte_idx;

	always_ff @(posedge clk_root) begin
		if (reset) begin
			state <= matrix_pkg::PS_IDLE;
			mask_is_colour <= 1'b0;
			line_num <= '0;
			byte_idx <= '0;
			wr_en <= 1'b0;
			rgb_enable <= '1;
			brightness_enable <= '1;
			commands_done <= '0;
		end else begin
			wr_en <= 1'b0;
			if (rx_valid) begin
				case (state)
					matrix_pkg::PS_IDLE: begin
						// unknown bytes fall through, not counted
						if (rx_data == CMD_LINE) begin
							state <= matrix_pkg::PS_LINE;
						end else if (rx_data == CMD_BRIGHT || rx_data == CMD_COLOUR) begin
							mask_is_colour <= (rx_data == CMD_COLOUR);
							state <= matrix_pkg::PS_MASK;
						end
					end
					matrix_pkg::PS_LINE: begin
						line_num <= rx_data[LINE_BITS-1:0];
						byte_idx <= '0;
						state <= matrix_pkg::PS_PIXEL;
					end
					matrix_pkg::PS_PIXEL: begin
						wr_en <= 1'b1;
						byte_idx <= byte_idx + 1'b1;
						// last byte of the line closes the command
						if (byte_idx == '1) begin
							commands_done <= commands_done + 1'b1;
							state <= matrix_pkg::PS_IDLE;
						end
					end
					matrix_pkg::PS_MASK: begin
						if (mask_is_colour)
							rgb_enable <= rx_data[2:0];
						else
							brightness_enable <= rx_data[4:0];
						commands_done <= commands_done + 1'b1;
						state <= matrix_pkg::PS_IDLE;
					end
					default: state <= matrix_pkg::PS_IDLE;
				endcase
			end
		end
	end

	// byte address is line * 32 + byte index, bit 0 low means high byte
	always_ff @(posedge clk_root) begin
		if (rx_valid && state == matrix_pkg::PS_PIXEL) begin
			wr_addr <= {line_num, byte_idx};
			wr_data <= rx_data;
		end
	end

	// every write lands inside the buffer
	// only the last byte of a line sends the parser back to idle
	a_write_in_range: assert property (@(posedge clk_root) disable iff (reset)
		wr_en |-> (wr_addr < 2 * `FB_WORDS) &&
			(state == matrix_pkg::PS_PIXEL || wr_addr[IDX_BITS-1:0] == '1));

endmodule

`default_nettype wire

// ==== design/framebuffer_fetch.sv ====
// top and bottom pixel fetch with plane bit select and enable masks
`timescale 1ns/1ps
`default_nettype none
`include "matrix_defs.svh"

module framebuffer_fetch (
	input  wire logic                       clk_root,
	input  wire logic                       reset,
	input  wire logic                       load_start,
	input  wire logic [3:0]                 column,
	input  wire logic [2:0]                 row_pair,
	input  wire logic [2:0]                 plane,
	input  wire logic [2:0]                 rgb_enable,
	input  wire logic [4:0]                 brightness_enable,
	input  wire matrix_pkg::fb_word_t       rd_data,
	output logic [`FB_ADDR_BITS-1:0]        rd_addr,
	output logic [2:0]                      rgb_top,
	output logic [2:0]                      rgb_bottom
);

	// one hot load pipeline, bits for t+1, t+2, t+3
	logic [2:0] pipe;
	logic [2:0] plane_l;
	matrix_pkg::fb_word_t top_word;

	// plane bit of each colour, green is one bit wider so it skips its lsb
	function automatic logic [2:0] plane_bits(input matrix_pkg::fb_word_t w,
		input logic [2:0] p);
		logic [2:0] colour;
		colour[0] = w.pixel.red[p];
		colour[1] = w.pixel.green[p + 1];
		colour[2] = w.pixel.blue[p];
		return colour & rgb_enable & {3{brightness_enable[p]}};
	endfunction

	always_ff @(posedge clk_root) begin
		if (reset) begin
			pipe <= '0;
			rgb_top <= '0;
			rgb_bottom <= '0;
		end else begin
			pipe <= {pipe[1:0], load_start};
			// bottom word on the bus during t+3, top word held from t+2
			if (pipe[2]) begin
				rgb_top <= plane_bits(top_word, plane_l);
				rgb_bottom <= plane_bits(rd_data, plane_l);
			end
		end
	end

	// address sequence, top line first then the same column eight lines down
	always_ff @(posedge clk_root) begin
		if (load_start) begin
			rd_addr <= {1'b0, row_pair, column};
			plane_l <= plane;
		end else if (pipe[0]) begin
			rd_addr[`FB_ADDR_BITS-1] <= 1'b1;
		end
		if (pipe[1])
			top_word <= rd_data;
	end

	// scan engine must space its loads past the fetch latency
	a_one_load: assert property (@(posedge clk_root) disable iff (reset)
		load_start |-> pipe == '0);

endmodule

`default_nettype wire

// ==== design/framebuffer_ram.sv ====
// dual-port framebuffer, byte lane writes and registered word reads
`timescale 1ns/1ps
`default_nettype none
`include "matrix_defs.svh"

module framebuffer_ram (
	input  wire logic                       clk_root,
	input  wire logic [`FB_ADDR_BITS:0]     wr_addr,
	input  wire logic [7:0]                 wr_data,
	input  wire logic                       wr_en,
	input  wire logic [`FB_ADDR_BITS-1:0]   rd_addr,
	output matrix_pkg::fb_word_t            rd_data
);

	matrix_pkg::fb_word_t mem [`FB_WORDS];

	// write side, one byte lane per write
	always_ff @(posedge clk_root) begin
		if (wr_en) begin
			if (!wr_addr[0])
				mem[wr_addr[`FB_ADDR_BITS:1]].bytes.high <= wr_data;
			else
				mem[wr_addr[`FB_ADDR_BITS:1]].bytes.low <= wr_data;
		end
	end

	// read side, one cycle latency
	always_ff @(posedge clk_root) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== design/led_matrix_top.sv ====
// led matrix driver top, receiver, parser, framebuffer, fetch and scan
`timescale 1ns/1ps
`default_nettype none
`include "matrix_defs.svh"

module led_matrix_top (
	input  wire logic   clk_root,
	input  wire logic   reset,
	input  wire logic   serial_in,
	output logic        pixel_clk,
	output logic        latch,
	output logic        output_enable_n,
	output logic [3:0]  row_address,
	output logic [2:0]  rgb_top,
	output logic [2:0]  rgb_bottom,
	output logic [7:0]  commands_done
);

	// receiver to parser
	logic [7:0] rx_data;
	logic rx_valid;
	// parser to framebuffer and fetch
	logic [`FB_ADDR_BITS:0] wr_addr;
	logic [7:0] wr_data;
	logic wr_en;
	logic [2:0] rgb_enable;
	logic [4:0] brightness_enable;
	// fetch read port
	logic [`FB_ADDR_BITS-1:0] rd_addr;
	matrix_pkg::fb_word_t rd_data;
	// scan requests
	logic [3:0] column;
	logic [2:0] row_pair;
	logic [2:0] plane;
	logic load_start;

	uart_rx u_uart_rx (
		.clk_root (clk_root),
		.reset    (reset),
		.rx       (serial_in),
		.rx_data  (rx_data),
		.rx_valid (rx_valid)
	);

	command_parser u_parser (
		.clk_root          (clk_root),
		.reset             (reset),
		.rx_data           (rx_data),
		.rx_valid          (rx_valid),
		.wr_addr           (wr_addr),
		.wr_data           (wr_data),
		.wr_en             (wr_en),
		.rgb_enable        (rgb_enable),
		.brightness_enable (brightness_enable),
		.commands_done     (commands_done)
	);

	framebuffer_ram u_ram (
		.clk_root (clk_root),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.wr_en    (wr_en),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	framebuffer_fetch u_fetch (
		.clk_root          (clk_root),
		.reset             (reset),
		.load_start        (load_start),
		.column            (column),
		.row_pair          (row_pair),
		.plane             (plane),
		.rgb_enable        (rgb_enable),
		.brightness_enable (brightness_enable),
		.rd_data           (rd_data),
		.rd_addr           (rd_addr),
		.rgb_top           (rgb_top),
		.rgb_bottom        (rgb_bottom)
	);

	matrix_scan u_scan (
		.clk_root        (clk_root),
		.reset           (reset),
		.column          (column),
		.row_pair        (row_pair),
		.plane           (plane),
		.load_start      (load_start),
		.pixel_clk       (pixel_clk),
		.latch           (latch),
		.output_enable_n (output_enable_n),
		.row_address     (row_address)
	);

endmodule

`default_nettype wire

// ==== design/matrix_defs.svh ====
// matrix geometry, plane count, scan and on-time timing, serial bit period
`ifndef MATRIX_DEFS_SVH
`define MATRIX_DEFS_SVH

// panel geometry, two display lines per scanned row pair
`define MATRIX_COLS 16
`define MATRIX_ROW_PAIRS 8

// binary coded modulation planes
`define MATRIX_PLANES 5

// clk_root cycles per scan tick, at least 5 so the fetch latency fits
`define SCAN_DIV 6
// on-time of plane 0 in scan ticks
`define OE_UNIT 2

// serial receiver
`define UART_TICKS_PER_BIT 4

// framebuffer depth in words and word address width
`define FB_WORDS (`MATRIX_COLS * `MATRIX_ROW_PAIRS * 2)
`define FB_ADDR_BITS $clog2(`FB_WORDS)

`endif

// ==== design/matrix_pkg.sv ====
// pixel struct, framebuffer word union and parser state enum
`default_nettype none

package matrix_pkg;

	// rgb565 pixel as stored in the framebuffer
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// byte lanes of one word, high byte comes first on the wire
	typedef struct packed {
		logic [7:0] high;
		logic [7:0] low;
	} byte_pair_t;

	// same word seen as a pixel by the fetch side, as bytes by the write side
	typedef union packed {
		rgb565_t    pixel;
		byte_pair_t bytes;
	} fb_word_t;

	// command decoder states
	typedef enum logic [1:0] {
		PS_IDLE,
		PS_LINE,
		PS_PIXEL,
		PS_MASK
	} parser_state_t;

endpackage

`default_nettype wire

// ==== design/matrix_scan.sv ====
// scan engine, column shift, latch, bcm on-time and row advance
`timescale 1ns/1ps
`default_nettype none
`include "matrix_defs.svh"

module matrix_scan (
	input  wire logic   clk_root,
	input  wire logic   reset,
	output logic [3:0]  column,
	output logic [2:0]  row_pair,
	output logic [2:0]  plane,
	output logic        load_start,
	output logic        pixel_clk,
	output logic        latch,
	output logic        output_enable_n,
	output logic [3:0]  row_address
);

	localparam int DW = $clog2(`SCAN_DIV);
	localparam int ON_MAX = `OE_UNIT << (`MATRIX_PLANES - 1);
	localparam int OW = $clog2(ON_MAX + 1);
	localparam logic [1:0] PH_SHIFT = 2'd0;
	localparam logic [1:0] PH_LATCH = 2'd1;
	localparam logic [1:0] PH_ON = 2'd2;

	logic [DW-1:0] div_cnt;
	logic tick;
	logic [1:0] phase;
	// low on tick a, high on tick b
	logic half;
	logic [OW-1:0] on_cnt;

	assign tick = (div_cnt == DW'(`SCAN_DIV - 1));

	always_ff @(posedge clk_root) begin
		if (reset) begin
			div_cnt <= '0;
			phase <= PH_SHIFT;
			half <= 1'b0;
			column <= '0;
			row_pair <= '0;
			plane <= '0;
			on_cnt <= '0;
			load_start <= 1'b0;
			pixel_clk <= 1'b0;
			latch <= 1'b0;
			output_enable_n <= 1'b1;
			row_address <= '0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			load_start <= 1'b0;
			if (tick) begin
				case (phase)
					PH_SHIFT: begin
						half <= ~half;
						if (!half) begin
							// tick a, request the pixel, clock low
							pixel_clk <= 1'b0;
							load_start <= 1'b1;
						end else begin
							// tick b, fetch has settled, clock in
							pixel_clk <= 1'b1;
							column <= column + 1'b1;
							if (column == 4'(`MATRIX_COLS - 1))
								phase <= PH_LATCH;
						end
					end
					PH_LATCH: begin
						if (!latch) begin
							latch <= 1'b1;
							pixel_clk <= 1'b0;
							row_address <= 4'(row_pair);
						end else begin
							// latch done, light the row for this plane's weight
							latch <= 1'b0;
							output_enable_n <= 1'b0;
							on_cnt <= OW'((`OE_UNIT << plane) - 1);
							phase <= PH_ON;
						end
					end
					PH_ON: begin
						if (on_cnt != '0) begin
							on_cnt <= on_cnt - 1'b1;
						end else begin
							output_enable_n <= 1'b1;
							phase <= PH_SHIFT;
							// next plane, row pair after the last plane
							if (plane == 3'(`MATRIX_PLANES - 1)) begin
								plane <= '0;
								row_pair <= row_pair + 1'b1;
							end else begin
								plane <= plane + 1'b1;
							end
						end
					end
					default: phase <= PH_SHIFT;
				endcase
			end
		end
	end

	// panel must be blank while the latch is open
	a_latch_blank: assert property (@(posedge clk_root) disable iff (reset)
		latch |-> output_enable_n);

endmodule

`default_nettype wire

// ==== design/uart_rx.sv ====
// 8n1 serial receiver with input synchroniser and mid-bit sampling
`timescale 1ns/1ps
`default_nettype none
`include "matrix_defs.svh"

module uart_rx (
	input  wire logic       clk_root,
	input  wire logic       reset,
	input  wire logic       rx,
	output logic [7:0]      rx_data,
	output logic            rx_valid
);

	localparam int TICKS = `UART_TICKS_PER_BIT;
	localparam int TW = $clog2(TICKS + 1);

	// two flop synchroniser, idle high
	logic [1:0] rx_sync;
	logic busy;
	logic [TW-1:0] tick_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_idx;
	logic [7:0] shift;

	always_ff @(posedge clk_root) begin
		if (reset) begin
			rx_sync <= 2'b11;
			busy <= 1'b0;
			tick_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			rx_valid <= 1'b0;
			if (!busy) begin
				// falling edge seen, wait half a bit to land mid start bit
				if (!rx_sync[1]) begin
					busy <= 1'b1;
					tick_cnt <= TW'(TICKS / 2 - 1);
					bit_idx <= '0;
				end
			end else if (tick_cnt != '0) begin
				tick_cnt <= tick_cnt - 1'b1;
			end else begin
				tick_cnt <= TW'(TICKS - 1);
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 4'd0) begin
					// glitch, start bit gone by mid-bit
					if (rx_sync[1])
						busy <= 1'b0;
				end else if (bit_idx == 4'd9) begin
					busy <= 1'b0;
					// stop bit must be high, else drop the byte
					rx_valid <= rx_sync[1];
				end
			end
		end
	end

	// lsb first, shift in from the top
	always_ff @(posedge clk_root) begin
		if (busy && tick_cnt == '0 && bit_idx >= 4'd1 && bit_idx <= 4'd8)
			shift <= {rx_sync[1], shift[7:1]};
	end

	assign rx_data = shift;

	// byte strobe is a single cycle
	a_valid_single: assert property (@(posedge clk_root) disable iff (reset)
		rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// ==== tb/led_matrix_tb.sv ====
// led matrix testbench, serial stimulus from the tests file, framebuffer model, frame checks
`timescale 1ns/1ps
`default_nettype none
`include "matrix_defs.svh"

module led_matrix_tb;

	localparam int COLS = `MATRIX_COLS;
	localparam int ROW_PAIRS = `MATRIX_ROW_PAIRS;
	localparam int PLANES = `MATRIX_PLANES;
	localparam int PASSES = ROW_PAIRS * PLANES;
	localparam int BIT_TICKS = `UART_TICKS_PER_BIT;
	localparam int CMD_TIMEOUT = 2000;
	// two full frames and some margin
	localparam int FRAME_TIMEOUT = 30000;
	// parser model states
	localparam int M_IDLE = 0;
	localparam int M_LINE = 1;
	localparam int M_PIXEL = 2;
	localparam int M_MASK = 3;

	logic clk_root;
	logic reset;
	logic serial_in;
	logic pixel_clk;
	logic latch;
	logic output_enable_n;
	logic [3:0] row_address;
	logic [2:0] rgb_top;
	logic [2:0] rgb_bottom;
	logic [7:0] commands_done;

	// framebuffer and mask model
	logic [15:0] fb_model [2 * ROW_PAIRS * COLS];
	logic [2:0] rgb_mask_m;
	logic [4:0] bright_mask_m;
	int m_state;
	int m_line;
	int m_idx;
	logic m_colour;

	logic [15:0] lfsr_state;
	int errors;
	int checks;
	logic aborted;
	logic monitor_on;

	// frame tracking
	int latch_count;
	int pclk_count;
	int on_plane;
	int oe_low;
	logic latch_q;
	logic pclk_q;
	logic oe_q;
	logic frame_armed;
	logic frame_active;
	logic frame_done;
	int frame_pixels;

	led_matrix_top dut (
		.clk_root        (clk_root),
		.reset           (reset),
		.serial_in       (serial_in),
		.pixel_clk       (pixel_clk),
		.latch           (latch),
		.output_enable_n (output_enable_n),
		.row_address     (row_address),
		.rgb_top         (rgb_top),
		.rgb_bottom      (rgb_bottom),
		.commands_done   (commands_done)
	);

	always #5 clk_root = ~clk_root;

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// galois lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_random_byte(output logic [7:0] b);
		int i;
		b = '0;
		// one lfsr step per bit taken
		for (i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// colour bits of plane p for one rgb565 word
	function automatic logic [2:0] plane_rule(input logic [15:0] w, input int p,
		input logic [2:0] ce, input logic [4:0] be);
		logic [2:0] b;
		b[0] = w[11 + p] & ce[0] & be[p];
		b[1] = w[5 + p + 1] & ce[1] & be[p];
		b[2] = w[p] & ce[2] & be[p];
		return b;
	endfunction

	// command rules applied to the model, one byte at a time
	task automatic model_byte(input logic [7:0] b);
		int word;
		case (m_state)
			M_IDLE: begin
				if (b == 8'h4C) begin
					m_state = M_LINE;
				end else if (b == 8'h42 || b == 8'h43) begin
					m_colour = (b == 8'h43);
					m_state = M_MASK;
				end
			end
			M_LINE: begin
				m_line = b[3:0];
				m_idx = 0;
				m_state = M_PIXEL;
			end
			M_PIXEL: begin
				word = m_line * COLS + m_idx / 2;
				// even byte index is the high byte
				if (m_idx % 2 == 0)
					fb_model[word][15:8] = b;
				else
					fb_model[word][7:0] = b;
				m_idx++;
				if (m_idx == 2 * COLS)
					m_state = M_IDLE;
			end
			default: begin
				if (m_colour)
					rgb_mask_m = b[2:0];
				else
					bright_mask_m = b[4:0];
				m_state = M_IDLE;
			end
		endcase
	endtask

	// 8n1 lsb first, plus one idle bit
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		int i;
		model_byte(b);
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 11; i++) begin
			serial_in = (i < 10) ? frame[i] : 1'b1;
			repeat (BIT_TICKS) @(posedge clk_root);
			#1;
		end
	endtask

	task automatic send_line(input logic [7:0] line_num, input logic [7:0] pattern,
		input logic random);
		logic [7:0] b;
		int i;
		send_byte(8'h4C);
		send_byte(line_num);
		for (i = 0; i < 2 * COLS; i++) begin
			if (random)
				draw_random_byte(b);
			else
				b = pattern;
			send_byte(b);
		end
	endtask

	task automatic wait_commands(input int n);
		int waited;
		waited = 0;
		while (commands_done !== 8'(n) && waited < CMD_TIMEOUT) begin
			@(posedge clk_root);
			#1;
			waited++;
		end
		checks++;
		if (commands_done !== 8'(n)) begin
			errors++;
			$display("timeout: commands_done never reached %0d, it stays at %0d",
				n, commands_done);
			aborted = 1'b1;
		end
	endtask

	// arm the monitor, it runs from one frame start to the next
	task automatic check_frame();
		int waited;
		waited = 0;
		frame_done = 1'b0;
		frame_armed = 1'b1;
		while (!frame_done && waited < FRAME_TIMEOUT) begin
			@(posedge clk_root);
			waited++;
		end
		#1;
		if (!frame_done) begin
			errors++;
			$display("timeout: no complete frame was scanned");
			aborted = 1'b1;
		end else begin
			check_value("frame_pixels", 16'(PASSES * COLS), 16'(frame_pixels));
		end
	endtask

	// panel pins sampled at the falling edge, away from dut updates
	always @(negedge clk_root) begin : pin_monitor
		int rp;
		int pl;
		if (monitor_on) begin
			if (latch && !latch_q) begin
				check_value("row_address", 16'((latch_count / PLANES) % ROW_PAIRS),
					16'(row_address));
				on_plane = latch_count % PLANES;
				latch_count++;
				pclk_count = 0;
				if (frame_active && latch_count % PASSES == 0) begin
					frame_active = 1'b0;
					frame_done = 1'b1;
				end else if (frame_armed && latch_count % PASSES == 0) begin
					frame_armed = 1'b0;
					frame_active = 1'b1;
					frame_pixels = 0;
				end
			end
			if (latch)
				check_value("output_enable_n", 16'h1, 16'(output_enable_n));
			if (pixel_clk && !pclk_q) begin
				// blank while columns shift
				check_value("output_enable_n", 16'h1, 16'(output_enable_n));
				if (frame_active) begin
					rp = (latch_count / PLANES) % ROW_PAIRS;
					pl = latch_count % PLANES;
					check_value("rgb_top", 16'(plane_rule(fb_model[rp * COLS + pclk_count],
						pl, rgb_mask_m, bright_mask_m)), 16'(rgb_top));
					check_value("rgb_bottom",
						16'(plane_rule(fb_model[(rp + ROW_PAIRS) * COLS + pclk_count],
						pl, rgb_mask_m, bright_mask_m)), 16'(rgb_bottom));
					frame_pixels++;
				end
				pclk_count++;
			end
			// on-time length follows the plane weight
			if (!output_enable_n)
				oe_low++;
			if (output_enable_n && !oe_q) begin
				check_value("oe_low_cycles", 16'((`OE_UNIT << on_plane) * `SCAN_DIV),
					16'(oe_low));
				oe_low = 0;
			end
			latch_q = latch;
			pclk_q = pixel_clk;
			oe_q = output_enable_n;
		end
	end

	initial begin : stimulus
		int fd;
		int n;
		int cnt;
		logic [7:0] v;
		logic [7:0] ln;
		logic [7:0] pat;
		string line;
		clk_root = 1'b0;
		reset = 1'b1;
		serial_in = 1'b1;
		errors = 0;
		checks = 0;
		aborted = 1'b0;
		monitor_on = 1'b0;
		lfsr_state = 16'd12201;
		rgb_mask_m = '1;
		bright_mask_m = '1;
		m_state = M_IDLE;
		m_line = 0;
		m_idx = 0;
		m_colour = 1'b0;
		latch_count = 0;
		pclk_count = 0;
		on_plane = 0;
		oe_low = 0;
		latch_q = 1'b0;
		pclk_q = 1'b0;
		oe_q = 1'b1;
		frame_armed = 1'b0;
		frame_active = 1'b0;
		frame_done = 1'b0;
		frame_pixels = 0;

		repeat (5) @(posedge clk_root);
		#1;
		reset = 1'b0;
		// reset values before the scan moves
		check_value("output_enable_n", 16'h1, 16'(output_enable_n));
		check_value("latch", 16'h0, 16'(latch));
		check_value("pixel_clk", 16'h0, 16'(pixel_clk));
		check_value("rgb_top", 16'h0, 16'(rgb_top));
		check_value("rgb_bottom", 16'h0, 16'(rgb_bottom));
		check_value("commands_done", 16'h0, 16'(commands_done));
		monitor_on = 1'b1;

		fd = $fopen("tb/matrix_tests.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the tests file tb/matrix_tests.txt");
			aborted = 1'b1;
		end
		while (!aborted && $fgets(line, fd) != 0) begin
			if (line.len() > 0 && line.getc(0) == "S") begin
				// anything that is not hex means a random byte
				cnt = $sscanf(line, "S %h", v);
				if (cnt != 1)
					draw_random_byte(v);
				send_byte(v);
			end else if (line.len() > 0 && line.getc(0) == "L") begin
				cnt = $sscanf(line, "L %h %h", ln, pat);
				send_line(ln, pat, cnt < 2);
			end else if (line.len() > 0 && line.getc(0) == "W") begin
				cnt = $sscanf(line, "W %d", n);
				wait_commands(n);
			end else if (line.len() > 0 && line.getc(0) == "F") begin
				check_frame();
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/matrix_tests.txt ====
# S hh sends one byte, rr in place of hh sends a random byte
# L ll pp sends a line command for line ll with 32 bytes of pp, rr for random, W n waits, F checks a frame
L 00 rr
L 01 ff
L 02 rr
L 03 a5
L 04 rr
L 05 rr
L 06 00
L 07 rr
L 08 rr
L 09 5a
L 0a rr
L 0b rr
L 0c 3c
L 0d rr
L 0e rr
L 0f rr
W 16
F
S 7e
S 43
S 05
S 00
S 42
S 15
W 18
F
L 15 rr
W 19
F
